/* rtl/csr_consts.svh */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// datapath and register numbering
`define CSR_DATA_W      32
`define CSR_NUM_W       14

`define CSR_HWI_N       8
`define CSR_TIMER_W     20

// ESTAT exception fields
`define CSR_ECODE_W     6
`define CSR_ESUB_W      9
`define CSR_ECODE_LSB   16
`define CSR_ESUB_LSB    22

`define CSR_ENTRY_ALIGN 6
`define CSR_PC_STEP     4

`define CSR_TI_BIT      11    // timer bit in ESTAT.IS and ECFG.LIE

`define CSR_TCFG_EN     0
`define CSR_TCFG_PER    1

`endif

/* rtl/csr_pkg.sv */
`include "csr_consts.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN
    } csr_op_e;

    // what the register file does with an accepted command
    typedef enum logic [2:0] {
        ACT_NONE,
        ACT_RD,
        ACT_WR,
        ACT_XCHG,
        ACT_ERTN,
        ACT_TRAP
    } csr_act_e;

    typedef enum logic [`CSR_NUM_W-1:0] {
        CRMD   = 'h0,
        PRMD   = 'h1,
        ECFG   = 'h4,
        ESTAT  = 'h5,
        ERA    = 'h6,
        BADV   = 'h7,
        EENTRY = 'hc,
        SAVE0  = 'h30,
        SAVE1  = 'h31,
        SAVE2  = 'h32,
        SAVE3  = 'h33,
        TCFG   = 'h41,
        TVAL   = 'h42,
        TICLR  = 'h44
    } csr_addr_e;

    typedef enum logic [`CSR_ECODE_W-1:0] {
        INT = 'h0,
        ADE = 'h8,
        ALE = 'h9,
        SYS = 'hb,
        BRK = 'hc,
        INE = 'hd
    } ecode_e;

endpackage

/* rtl/csr_cmd_if.sv */
`include "csr_consts.svh"

// one accepted command, valid only in its acceptance cycle
interface csr_cmd_if;

    csr_pkg::csr_act_e         act;
    logic [`CSR_NUM_W-1:0]     num;
    logic [`CSR_DATA_W-1:0]    wdata;
    logic [`CSR_DATA_W-1:0]    wmask;
    logic [`CSR_DATA_W-1:0]    pc;
    csr_pkg::ecode_e           ecode;
    logic [`CSR_ESUB_W-1:0]    esubcode;
    logic [`CSR_DATA_W-1:0]    badv;

    modport issue (
        output act, num, wdata, wmask, pc, ecode, esubcode, badv
    );

    modport file (
        input act, num, wdata, wmask, pc, ecode, esubcode, badv
    );

    modport redirect (
        input act, pc
    );

endinterface

/* rtl/csr_issue.sv */
`include "csr_consts.svh"

module csr_issue (
    input  logic                      stall,
    input  logic                      flush,
    input  csr_pkg::csr_op_e          op,
    input  logic [`CSR_NUM_W-1:0]     num,
    input  logic [`CSR_DATA_W-1:0]    wdata,
    input  logic [`CSR_DATA_W-1:0]    wmask,
    input  logic [`CSR_DATA_W-1:0]    pc,
    input  logic                      excp_valid,
    input  logic [`CSR_ECODE_W-1:0]   ecode,
    input  logic [`CSR_ESUB_W-1:0]    esubcode,
    input  logic [`CSR_DATA_W-1:0]    badv,
    input  logic                      int_pending,
    csr_cmd_if.issue                  cmd
);

    logic accept;

    assign accept = !stall && !flush;

    always_comb
    begin
        cmd.act      = csr_pkg::ACT_NONE;
        cmd.num      = num;
        cmd.wdata    = wdata;
        cmd.wmask    = '0;
        cmd.pc       = pc;
        cmd.ecode    = csr_pkg::ecode_e'(ecode);
        cmd.esubcode = esubcode;
        cmd.badv     = badv;

        if (int_pending)    // interrupts get in regardless of stall/flush
        begin
            cmd.act      = csr_pkg::ACT_TRAP;
            cmd.ecode    = csr_pkg::INT;
            cmd.esubcode = '0;
        end
        else if (accept)
        begin
            if (excp_valid)
                cmd.act = csr_pkg::ACT_TRAP;
            else
            begin
                case (op)
                    csr_pkg::OP_CSRRD:
                        cmd.act = csr_pkg::ACT_RD;
                    csr_pkg::OP_CSRWR:
                    begin
                        cmd.act   = csr_pkg::ACT_WR;
                        cmd.wmask = '1;    // full word
                    end
                    csr_pkg::OP_CSRXCHG:
                    begin
                        cmd.act   = csr_pkg::ACT_XCHG;
                        cmd.wmask = wmask;
                    end
                    csr_pkg::OP_ERTN:
                        cmd.act = csr_pkg::ACT_ERTN;
                    default:
                        cmd.act = csr_pkg::ACT_NONE;
                endcase
            end
        end
    end

endmodule

/* rtl/csr_file.sv */
`include "csr_consts.svh"

module csr_file (
    input  logic                       clk,
    input  logic                       rstn,
    csr_cmd_if.file                    cmd,
    input  logic [`CSR_HWI_N-1:0]      hw_int,
    input  logic                       ti,
    input  logic [`CSR_TIMER_W-1:0]    tval,
    output logic                       tcfg_we,
    output logic [`CSR_TIMER_W-1:0]    tcfg_value,
    output logic                       ti_clear,
    output logic                       int_pending,
    output logic [`CSR_DATA_W-1:0]     era,
    output logic [`CSR_DATA_W-1:0]     eentry,
    output logic [1:0]                 crmd_plv,
    output logic                       crmd_ie,
    output logic [`CSR_DATA_W-1:0]     rdata
);

    logic [1:0]                                  prmd_pplv;
    logic                                        prmd_pie;
    logic [`CSR_TI_BIT:0]                        ecfg_lie;
    logic [1:0]                                  estat_is;    // software interrupts
    logic [`CSR_ECODE_W-1:0]                     estat_ecode;
    logic [`CSR_ESUB_W-1:0]                      estat_esub;
    logic [`CSR_DATA_W-1:0]                      badv;
    logic [`CSR_DATA_W-1:`CSR_ENTRY_ALIGN]       eentry_hi;
    logic [`CSR_DATA_W-1:0]                      save [4];
    logic [`CSR_TIMER_W-1:0]                     tcfg;
    logic [`CSR_DATA_W-1:0]                      old;
    logic [`CSR_DATA_W-1:0]                      merged;
    logic [`CSR_TI_BIT:0]                        pending;
    logic                                        wr;

    assign wr      = cmd.act == csr_pkg::ACT_WR || cmd.act == csr_pkg::ACT_XCHG;
    assign merged  = (old & ~cmd.wmask) | (cmd.wdata & cmd.wmask);
    assign pending = {ti, 1'b0, hw_int, estat_is} & ecfg_lie;

    assign int_pending = crmd_ie && |pending;
    assign eentry      = {eentry_hi, {`CSR_ENTRY_ALIGN{1'b0}}};

    // timer side effects land at the same edge as the register write
    assign tcfg_we    = wr && cmd.num == csr_pkg::TCFG;
    assign tcfg_value = merged[`CSR_TIMER_W-1:0];
    assign ti_clear   = wr && cmd.num == csr_pkg::TICLR && merged[0];

    always_comb
    begin
        case (cmd.num)
            csr_pkg::CRMD:
                old = {{(`CSR_DATA_W-3){1'b0}}, crmd_ie, crmd_plv};
            csr_pkg::PRMD:
                old = {{(`CSR_DATA_W-3){1'b0}}, prmd_pie, prmd_pplv};
            csr_pkg::ECFG:
                old = {{(`CSR_DATA_W-`CSR_TI_BIT-1){1'b0}}, ecfg_lie};
            csr_pkg::ESTAT:
                old = {1'b0, estat_esub, estat_ecode, 4'b0, ti, 1'b0, hw_int, estat_is};
            csr_pkg::ERA:
                old = era;
            csr_pkg::BADV:
                old = badv;
            csr_pkg::EENTRY:
                old = eentry;
            csr_pkg::SAVE0, csr_pkg::SAVE1, csr_pkg::SAVE2, csr_pkg::SAVE3:
                old = save[cmd.num[1:0]];
            csr_pkg::TCFG:
                old = {{(`CSR_DATA_W-`CSR_TIMER_W){1'b0}}, tcfg};
            csr_pkg::TVAL:
                old = {{(`CSR_DATA_W-`CSR_TIMER_W){1'b0}}, tval};
            default:
                old = '0;    // TICLR and unimplemented numbers
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
            ecfg_lie  <= '0;
            estat_is  <= '0;
            tcfg      <= '0;
            rdata     <= '0;
        end
        else
        begin
            if (wr || cmd.act == csr_pkg::ACT_RD)
                rdata <= old;
            if (tcfg_we)
                tcfg <= tcfg_value;
            case (cmd.act)
                csr_pkg::ACT_WR, csr_pkg::ACT_XCHG:
                begin
                    case (cmd.num)
                        csr_pkg::CRMD:
                        begin
                            crmd_plv <= merged[1:0];
                            crmd_ie  <= merged[2];
                        end
                        csr_pkg::PRMD:
                        begin
                            prmd_pplv <= merged[1:0];
                            prmd_pie  <= merged[2];
                        end
                        csr_pkg::ECFG:    // bit 10 reserved
                            ecfg_lie <= {merged[`CSR_TI_BIT], 1'b0, merged[`CSR_HWI_N+1:0]};
                        csr_pkg::ESTAT:
                            estat_is <= merged[1:0];
                        default: ;
                    endcase
                end
                csr_pkg::ACT_TRAP:
                begin
                    prmd_pplv <= crmd_plv;
                    prmd_pie  <= crmd_ie;
                    crmd_plv  <= '0;
                    crmd_ie   <= 1'b0;
                end
                csr_pkg::ACT_ERTN:
                begin
                    crmd_plv <= prmd_pplv;
                    crmd_ie  <= prmd_pie;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr)
        begin
            case (cmd.num)
                csr_pkg::ERA:
                    era <= merged;
                csr_pkg::BADV:
                    badv <= merged;
                csr_pkg::EENTRY:
                    eentry_hi <= merged[`CSR_DATA_W-1:`CSR_ENTRY_ALIGN];
                csr_pkg::SAVE0, csr_pkg::SAVE1, csr_pkg::SAVE2, csr_pkg::SAVE3:
                    save[cmd.num[1:0]] <= merged;
                default: ;
            endcase
        end
        else if (cmd.act == csr_pkg::ACT_TRAP)
        begin
            era         <= cmd.pc;
            estat_ecode <= cmd.ecode;
            estat_esub  <= cmd.esubcode;
            if (cmd.ecode != csr_pkg::INT)    // interrupts carry no bad address
                badv <= cmd.badv;
        end
    end

endmodule

/* rtl/csr_timer.sv */
`include "csr_consts.svh"

module csr_timer (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       tcfg_we,
    input  logic [`CSR_TIMER_W-1:0]    tcfg_value,
    input  logic                       ti_clear,
    output logic [`CSR_TIMER_W-1:0]    tval,
    output logic                       ti
);

    logic                          en;
    logic                          periodic;
    logic [`CSR_TIMER_W-1:2]       init_val;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            en       <= 1'b0;
            periodic <= 1'b0;
            tval     <= '0;
        end
        else if (tcfg_we)
        begin
            en       <= tcfg_value[`CSR_TCFG_EN];
            periodic <= tcfg_value[`CSR_TCFG_PER];
            tval     <= {tcfg_value[`CSR_TIMER_W-1:2], 2'b00};
        end
        else if (en)
        begin
            if (tval != '0)
                tval <= tval - 1'b1;
            else if (periodic)
                tval <= {init_val, 2'b00};    // reload after expiry
        end
    end

    always_ff @(posedge clk)
    begin
        if (tcfg_we)
            init_val <= tcfg_value[`CSR_TIMER_W-1:2];
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            ti <= 1'b0;
        else if (ti_clear)
            ti <= 1'b0;
        else if (en && !tcfg_we && tval == `CSR_TIMER_W'(1))
            ti <= 1'b1;    // 1 -> 0 step
    end

endmodule

/* rtl/csr_redirect.sv */
`include "csr_consts.svh"

module csr_redirect (
    input  logic                      clk,
    input  logic                      rstn,
    csr_cmd_if.redirect               cmd,
    input  logic [`CSR_DATA_W-1:0]    era,
    input  logic [`CSR_DATA_W-1:0]    eentry,
    output logic                      redirect,
    output logic [`CSR_DATA_W-1:0]    redirect_pc
);

    logic redirect_next;

    // reads never redirect
    assign redirect_next = cmd.act == csr_pkg::ACT_WR
                        || cmd.act == csr_pkg::ACT_XCHG
                        || cmd.act == csr_pkg::ACT_ERTN
                        || cmd.act == csr_pkg::ACT_TRAP;

    always_ff @(posedge clk)
    begin
        if (!rstn)
            redirect <= 1'b0;
        else
            redirect <= redirect_next;
    end

    // era and eentry are sampled before the file updates them
    always_ff @(posedge clk)
    begin
        case (cmd.act)
            csr_pkg::ACT_WR, csr_pkg::ACT_XCHG:
                redirect_pc <= cmd.pc + `CSR_DATA_W'(`CSR_PC_STEP);
            csr_pkg::ACT_ERTN:
                redirect_pc <= era;
            csr_pkg::ACT_TRAP:
                redirect_pc <= eentry;
            default: ;
        endcase
    end

endmodule

/* rtl/csr_control.sv */
`include "csr_consts.svh"

module csr_control (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      stall,
    input  logic                      flush,
    input  csr_pkg::csr_op_e          op,
    input  logic [`CSR_NUM_W-1:0]     num,
    input  logic [`CSR_DATA_W-1:0]    wdata,
    input  logic [`CSR_DATA_W-1:0]    wmask,
    input  logic [`CSR_DATA_W-1:0]    pc,
    input  logic                      excp_valid,
    input  logic [`CSR_ECODE_W-1:0]   ecode,
    input  logic [`CSR_ESUB_W-1:0]    esubcode,
    input  logic [`CSR_DATA_W-1:0]    badv,
    input  logic [`CSR_HWI_N-1:0]     hw_int,
    output logic [`CSR_DATA_W-1:0]    rdata,
    output logic                      redirect,
    output logic [`CSR_DATA_W-1:0]    redirect_pc,
    output logic [1:0]                crmd_plv,
    output logic                      crmd_ie
);

    logic                          int_pending;
    logic [`CSR_DATA_W-1:0]        era;
    logic [`CSR_DATA_W-1:0]        eentry;
    logic                          ti;
    logic [`CSR_TIMER_W-1:0]       tval;
    logic                          tcfg_we;
    logic [`CSR_TIMER_W-1:0]       tcfg_value;
    logic                          ti_clear;

    csr_cmd_if cmd_bus ();

    csr_issue u_issue (
        .stall       (stall),
        .flush       (flush),
        .op          (op),
        .num         (num),
        .wdata       (wdata),
        .wmask       (wmask),
        .pc          (pc),
        .excp_valid  (excp_valid),
        .ecode       (ecode),
        .esubcode    (esubcode),
        .badv        (badv),
        .int_pending (int_pending),
        .cmd         (cmd_bus.issue)
    );

    csr_file u_file (
        .clk         (clk),
        .rstn        (rstn),
        .cmd         (cmd_bus.file),
        .hw_int      (hw_int),
        .ti          (ti),
        .tval        (tval),
        .tcfg_we     (tcfg_we),
        .tcfg_value  (tcfg_value),
        .ti_clear    (ti_clear),
        .int_pending (int_pending),
        .era         (era),
        .eentry      (eentry),
        .crmd_plv    (crmd_plv),
        .crmd_ie     (crmd_ie),
        .rdata       (rdata)
    );

    csr_timer u_timer (
        .clk         (clk),
        .rstn        (rstn),
        .tcfg_we     (tcfg_we),
        .tcfg_value  (tcfg_value),
        .ti_clear    (ti_clear),
        .tval        (tval),
        .ti          (ti)
    );

    csr_redirect u_redirect (
        .clk         (clk),
        .rstn        (rstn),
        .cmd         (cmd_bus.redirect),
        .era         (era),
        .eentry      (eentry),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

/* sim/csr_control_properties.sv */
`include "csr_consts.svh"

module csr_control_properties (
    input logic                      clk,
    input logic                      rstn,
    input logic                      stall,
    input logic                      flush,
    input csr_pkg::csr_op_e          op,
    input logic                      excp_valid,
    input logic                      int_pending,
    input logic                      redirect,
    input logic [`CSR_DATA_W-1:0]    redirect_pc
);

    logic accept;
    logic trap;
    logic redir_cmd;

    assign accept    = !stall && !flush;
    assign trap      = int_pending || (accept && excp_valid);
    assign redir_cmd = trap || (accept && (op == csr_pkg::OP_CSRWR
                                        || op == csr_pkg::OP_CSRXCHG
                                        || op == csr_pkg::OP_ERTN));

    reset_quiet: assert property (@(posedge clk) $rose(rstn) |=> !redirect)
        else $error("redirect high in the first cycle after reset");

    // every pulse cycle needs a redirecting command one cycle earlier
    pulse_per_cmd: assert property (@(posedge clk) disable iff (!rstn)
        redirect |-> $past(redir_cmd))
        else $error("redirect held without a command behind it");

    trap_aligned: assert property (@(posedge clk) disable iff (!rstn)
        trap |=> redirect && redirect_pc[`CSR_ENTRY_ALIGN-1:0] == '0)
        else $error("trap target not aligned to the entry boundary");

endmodule

bind csr_control csr_control_properties u_props (
    .clk         (clk),
    .rstn        (rstn),
    .stall       (stall),
    .flush       (flush),
    .op          (op),
    .excp_valid  (excp_valid),
    .int_pending (int_pending),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
);

/* sim/csr_control_tb.sv */
`include "csr_consts.svh"

module csr_control_tb;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_STEPS  = 64;

    logic                      clk;
    logic                      rstn;
    logic                      stall;
    logic                      flush;
    csr_pkg::csr_op_e          op;
    logic [`CSR_NUM_W-1:0]     num;
    logic [`CSR_DATA_W-1:0]    wdata;
    logic [`CSR_DATA_W-1:0]    wmask;
    logic [`CSR_DATA_W-1:0]    pc;
    logic                      excp_valid;
    logic [`CSR_ECODE_W-1:0]   ecode;
    logic [`CSR_ESUB_W-1:0]    esubcode;
    logic [`CSR_DATA_W-1:0]    badv;
    logic [`CSR_HWI_N-1:0]     hw_int;
    logic [`CSR_DATA_W-1:0]    rdata;
    logic                      redirect;
    logic [`CSR_DATA_W-1:0]    redirect_pc;
    logic [1:0]                crmd_plv;
    logic                      crmd_ie;

    logic [31:0]               tr_kind [MAX_STEPS];
    logic [31:0]               tr_f [MAX_STEPS][15];    // columns after the kind
    int                        n_steps;
    logic                      loaded;
    logic [`CSR_DATA_W-1:0]    save_model [4];
    logic [`CSR_DATA_W-1:0]    last_rdata;
    logic                      rd_known;
    int                        i;

    csr_control dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush       (flush),
        .op          (op),
        .num         (num),
        .wdata       (wdata),
        .wmask       (wmask),
        .pc          (pc),
        .excp_valid  (excp_valid),
        .ecode       (ecode),
        .esubcode    (esubcode),
        .badv        (badv),
        .hw_int      (hw_int),
        .rdata       (rdata),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .crmd_plv    (crmd_plv),
        .crmd_ie     (crmd_ie)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic end_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_data(string name, logic [`CSR_DATA_W-1:0] got,
                              logic [`CSR_DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_pc(logic [`CSR_DATA_W-1:0] got, logic [`CSR_DATA_W-1:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED redirect_pc got %h expected %h", got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_act(logic got, csr_pkg::csr_act_e act);
        logic exp;
        exp = act inside {csr_pkg::ACT_WR, csr_pkg::ACT_XCHG,
                          csr_pkg::ACT_ERTN, csr_pkg::ACT_TRAP};
        if (got !== exp)
        begin
            $display("CHECK FAILED redirect got %h expected %h for %s", got, exp, act.name());
            end_with_failure();
        end
    endtask

    task automatic check_mode(logic [1:0] plv, logic ie, logic [2:0] exp);
        if ({ie, plv} !== exp)
        begin
            $display("CHECK FAILED crmd_ie,crmd_plv got %h expected %h", {ie, plv}, exp);
            end_with_failure();
        end
    endtask

    function automatic logic [`CSR_DATA_W-1:0] merge(input logic [`CSR_DATA_W-1:0] old_v,
                                                     input logic [`CSR_DATA_W-1:0] new_v,
                                                     input logic [`CSR_DATA_W-1:0] mask);
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    task automatic load_trace();
        int                  fd;
        int                  cnt;
        logic [8*256-1:0]    line;
        logic [31:0]         kind;
        logic [31:0]         f [15];
        fd = $fopen("sim/csr_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the trace file sim/csr_trace.txt");
            end_with_failure();
        end
        while (!$feof(fd))
        begin
            line = '0;
            cnt  = $fgets(line, fd);
            cnt  = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           kind, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                           f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (cnt == 16 && n_steps < MAX_STEPS)    // comments and blank lines drop out
            begin
                tr_kind[n_steps] = kind;
                for (int k = 0; k < 15; k++)
                    tr_f[n_steps][k] = f[k];
                n_steps++;
            end
        end
        $fclose(fd);
        if (n_steps == 0)
        begin
            $display("the trace file holds no steps");
            end_with_failure();
        end
    endtask

    task automatic drive_idle();
        op         <= csr_pkg::OP_NONE;
        excp_valid <= 1'b0;
        stall      <= 1'b0;
        flush      <= 1'b0;
    endtask

    task automatic issue_step(int idx, logic check_rd);
        csr_pkg::csr_act_e         act;
        logic [`CSR_DATA_W-1:0]    exp_rd;
        logic [`CSR_DATA_W-1:0]    exp_pc;
        logic                      is_save;
        logic                      reads;
        logic [1:0]                s;
        act     = csr_pkg::csr_act_e'(tr_f[idx][11][2:0]);
        is_save = tr_f[idx][1] >= 32'h30 && tr_f[idx][1] <= 32'h33;
        s       = tr_f[idx][1][1:0];
        reads   = act inside {csr_pkg::ACT_RD, csr_pkg::ACT_WR, csr_pkg::ACT_XCHG};
        @(posedge clk);
        op         <= csr_pkg::csr_op_e'(tr_f[idx][0][2:0]);
        num        <= tr_f[idx][1][`CSR_NUM_W-1:0];
        wdata      <= tr_f[idx][2];
        wmask      <= tr_f[idx][3];
        pc         <= tr_f[idx][4];
        excp_valid <= tr_f[idx][5][0];
        ecode      <= tr_f[idx][6][`CSR_ECODE_W-1:0];
        esubcode   <= tr_f[idx][7][`CSR_ESUB_W-1:0];
        badv       <= tr_f[idx][8];
        stall      <= tr_f[idx][9][0];
        flush      <= tr_f[idx][10][0];
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        exp_rd = is_save ? save_model[s] : tr_f[idx][12];
        if (reads && check_rd)
            check_data("rdata", rdata, exp_rd);
        else if (!reads && rd_known)
            check_data("rdata", rdata, last_rdata);    // held since the last read
        if (reads)
        begin
            last_rdata = exp_rd;
            rd_known   = check_rd;
        end
        if (is_save && act == csr_pkg::ACT_WR)
            save_model[s] = merge(save_model[s], tr_f[idx][2], {`CSR_DATA_W{1'b1}});
        else if (is_save && act == csr_pkg::ACT_XCHG)
            save_model[s] = merge(save_model[s], tr_f[idx][2], tr_f[idx][3]);
        exp_pc = tr_f[idx][13];
        if (act == csr_pkg::ACT_WR || act == csr_pkg::ACT_XCHG)
            exp_pc = tr_f[idx][4] + `CSR_PC_STEP;
        check_act(redirect, act);
        if (redirect)
            check_pc(redirect_pc, exp_pc);
        check_mode(crmd_plv, crmd_ie, tr_f[idx][14][2:0]);
    endtask

    // the bound sits in the num column
    task automatic wait_for_interrupt(int idx);
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!redirect && n < tr_f[idx][1]);
        if (!redirect)
        begin
            $display("no interrupt redirect within %0d cycles at step %0d", tr_f[idx][1], idx);
            end_with_failure();
        end
        check_act(redirect, csr_pkg::ACT_TRAP);
        check_pc(redirect_pc, tr_f[idx][13]);
        check_mode(crmd_plv, crmd_ie, tr_f[idx][14][2:0]);
    endtask

    initial
    begin
        wait (loaded);
        repeat (n_steps * (64 + 4)) @(posedge clk);
        $display("watchdog expired before the trace was finished");
        end_with_failure();
    end

    initial
    begin
        void'($urandom(32'h3cb5));
        clk        = 1'b0;
        rstn       = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        op         = csr_pkg::OP_NONE;
        num        = '0;
        wdata      = '0;
        wmask      = '0;
        pc         = '0;
        excp_valid = 1'b0;
        ecode      = '0;
        esubcode   = '0;
        badv       = '0;
        hw_int     = '0;
        last_rdata = '0;
        rd_known   = 1'b1;
        n_steps    = 0;
        loaded     = 1'b0;
        load_trace();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_data("rdata", rdata, '0);
        check_act(redirect, csr_pkg::ACT_NONE);
        check_mode(crmd_plv, crmd_ie, 3'b000);
        for (i = 0; i < n_steps; i++)
        begin
            if (tr_kind[i] == "wait")
                wait_for_interrupt(i);
            else
            begin
                repeat ($urandom % 3) @(posedge clk);
                issue_step(i, tr_kind[i] != "init");    // init: old value unknown
            end
        end
        $display("All tests passed");
        $finish;
    end

endmodule

/* csr_control.f */
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_cmd_if.sv
rtl/csr_issue.sv
rtl/csr_file.sv
rtl/csr_timer.sv
rtl/csr_redirect.sv
rtl/csr_control.sv
sim/csr_control_properties.sv
sim/csr_control_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := csr_control_tb
FILELIST  := csr_control.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/csr_trace.txt */
# kind op num wdata wmask pc excp ecode esub badv stall flush act rdata rpc mode (hex)
# act is the expected action, mode is {ie,plv} afterwards, a wait line puts its cycle bound in num
init 2 30 11112222 00000000 1c000100 0 0 0 00000000 0 0 2 00000000 00000000 0
cmd  2 30 33334444 00000000 1c000104 0 0 0 00000000 0 0 2 11112222 00000000 0
cmd  1 30 00000000 00000000 1c000108 0 0 0 00000000 0 0 1 33334444 00000000 0
init 2 31 a5a5a5a5 00000000 1c00010c 0 0 0 00000000 0 0 2 00000000 00000000 0
cmd  3 31 5a5a5a5a ffff0000 1c000110 0 0 0 00000000 0 0 3 a5a5a5a5 00000000 0
cmd  1 31 00000000 00000000 1c000114 0 0 0 00000000 0 0 1 5a5aa5a5 00000000 0
# stall, flush and a stalled exception change nothing
cmd  2 30 deadbeef 00000000 1c000118 0 0 0 00000000 1 0 0 00000000 00000000 0
cmd  2 30 deadbeef 00000000 1c000118 0 0 0 00000000 0 1 0 00000000 00000000 0
cmd  0 0  00000000 00000000 1c00011c 1 b 0 00000000 1 0 0 00000000 00000000 0
cmd  1 30 00000000 00000000 1c000120 0 0 0 00000000 0 0 1 33334444 00000000 0
# exception entry and return
init 2 c  1c000040 00000000 1c000124 0 0 0 00000000 0 0 2 00000000 00000000 0
cmd  2 0  00000007 00000000 1c000128 0 0 0 00000000 0 0 2 00000000 00000000 7
cmd  0 0  00000000 00000000 1c00012c 1 b 5 12345678 0 0 5 00000000 1c000040 0
cmd  1 6  00000000 00000000 1c000130 0 0 0 00000000 0 0 1 1c00012c 00000000 0
cmd  1 5  00000000 00000000 1c000134 0 0 0 00000000 0 0 1 014b0000 00000000 0
cmd  1 7  00000000 00000000 1c000138 0 0 0 00000000 0 0 1 12345678 00000000 0
cmd  1 1  00000000 00000000 1c00013c 0 0 0 00000000 0 0 1 00000007 00000000 0
cmd  1 c  00000000 00000000 1c000140 0 0 0 00000000 0 0 1 1c000040 00000000 0
cmd  4 0  00000000 00000000 1c000144 0 0 0 00000000 0 0 4 00000000 1c00012c 7
# timer interrupt
cmd  2 4  00000800 00000000 1c000148 0 0 0 00000000 0 0 2 00000000 00000000 7
cmd  2 41 00000011 00000000 1c00014c 0 0 0 00000000 0 0 2 00000000 00000000 7
cmd  2 0  00000004 00000000 1c000150 0 0 0 00000000 0 0 2 00000007 00000000 4
wait 0 28 00000000 00000000 00000000 0 0 0 00000000 0 0 5 00000000 1c000040 0
cmd  1 5  00000000 00000000 1c000154 0 0 0 00000000 0 0 1 00000800 00000000 0
cmd  2 44 00000001 00000000 1c000158 0 0 0 00000000 0 0 2 00000000 00000000 0
cmd  1 5  00000000 00000000 1c00015c 0 0 0 00000000 0 0 1 00000000 00000000 0
cmd  1 6  00000000 00000000 1c000160 0 0 0 00000000 0 0 1 1c000150 00000000 0
cmd  4 0  00000000 00000000 1c000164 0 0 0 00000000 0 0 4 00000000 1c000150 4
cmd  1 42 00000000 00000000 1c000168 0 0 0 00000000 0 0 1 00000000 00000000 4
